//--- list.f
source/video_pkg.sv
source/video_timing.sv
source/tile_layer.sv
source/sprite_layer.sv
source/color_mix.sv
source/video_top.sv
sim/tb_video_top.sv

//--- run.sh
#!/bin/sh
# Build and run the video testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f list.f --top-module tb_video_top -o tb_video_top
./obj_dir/tb_video_top | tee sim.log
if grep -q "tests failed" sim.log; then
	echo "simulation reported failure, see sim.log"
	exit 1
fi
echo "simulation clean, see sim.log"
exit 0

//--- sim/tb_video_top.sv
// Video top level testbench
// Checks raster timing and every pixel against a tile and sprite reference model
`timescale 1ns/1ns

module tb_video_top;
	import video_pkg::*;

	logic        clk_24576m;
	logic        rst_n;
	logic        tile_wr;
	tile_addr_t  tile_addr;
	shade_t      tile_shade;
	color_t      tile_color;
	logic        spr_wr;
	sprite_idx_t spr_idx;
	scr_pos_t    spr_x;
	scr_pos_t    spr_y;
	shade_t      spr_shade;
	color_t      spr_color;
	logic [2:0]  vga_r;
	logic [2:0]  vga_g;
	logic [1:0]  vga_b;
	logic        h_blank;
	logic        v_blank;
	logic        h_sync_n;
	logic        v_sync_n;

	// Scenario table with tiles as {shade, colour} and sprites as {x, y, shade, colour}
	logic [5:0]  tile_tab [4][16];
	logic [15:0] spr_tab [4][4];

	// Reference model of what the DUT holds
	int          m_tsh [16];
	int          m_tco [16];
	int          m_sx [4];
	int          m_sy [4];
	int          m_ssh [4];
	int          m_sco [4];

	logic [31:0] lfsr;
	int          pixel_errs;
	int          timing_errs;
	int          other_errs;
	logic        timed_out;
	localparam int wait_limit = 2 * h_total * v_total;

	video_top video_top_inst (
		.clk_24576m(clk_24576m), .rst_n(rst_n),
		.tile_wr(tile_wr), .tile_addr(tile_addr),
		.tile_shade(tile_shade), .tile_color(tile_color),
		.spr_wr(spr_wr), .spr_idx(spr_idx), .spr_x(spr_x), .spr_y(spr_y),
		.spr_shade(spr_shade), .spr_color(spr_color),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
		.h_blank(h_blank), .v_blank(v_blank),
		.h_sync_n(h_sync_n), .v_sync_n(v_sync_n)
	);

	initial begin
		clk_24576m = 1'b0;
		forever #5 clk_24576m = ~clk_24576m;
	end

	// ========================================
	// Helpers
	// ========================================
	// One clock, then settle 1 ns past the edge
	task automatic step();
		@(posedge clk_24576m);
		#1;
	endtask

	// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	task automatic fill_random(input int s);
		logic [15:0] v;
		for (int i = 0; i < 16; i++) begin
			take_bits(6, v);
			tile_tab[s][i] = v[5:0];
		end
		for (int i = 0; i < 4; i++) begin
			take_bits(16, v);
			spr_tab[s][i] = v;
		end
	endtask

	task automatic end_run();
		$display("errors: pixel %0d, timing %0d, other %0d", pixel_errs, timing_errs,
			other_errs);
		if (pixel_errs + timing_errs + other_errs == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	endtask

	// Poll v_blank until it reaches the level or the wait gives up
	task automatic wait_vblank(input logic level);
		int n;
		n = 0;
		if (timed_out)
			return;
		while (v_blank !== level && n < wait_limit) begin
			step();
			n++;
		end
		if (v_blank !== level) begin
			$display("timeout: v_blank never reached %b", level);
			other_errs++;
			timed_out = 1'b1;
		end
	endtask

	// Tile and sprite strobes share the first 4 cycles
	task automatic apply_scenario(input int s);
		for (int i = 0; i < 16; i++) begin
			tile_wr    = 1'b1;
			tile_addr  = tile_addr_t'(i);
			tile_shade = tile_tab[s][i][5:4];
			tile_color = tile_tab[s][i][3:0];
			m_tsh[i]   = int'(tile_tab[s][i][5:4]);
			m_tco[i]   = int'(tile_tab[s][i][3:0]);
			spr_wr     = (i < 4);
			if (i < 4) begin
				spr_idx   = sprite_idx_t'(i);
				{spr_x, spr_y, spr_shade, spr_color} = spr_tab[s][i];
				m_sx[i]   = int'(spr_tab[s][i][15:11]);
				m_sy[i]   = int'(spr_tab[s][i][10:6]);
				m_ssh[i]  = int'(spr_tab[s][i][5:4]);
				m_sco[i]  = int'(spr_tab[s][i][3:0]);
			end
			step();
		end
		tile_wr = 1'b0;
		spr_wr  = 1'b0;
	endtask

	// ========================================
	// Reference model
	// ========================================
	// Sprite over tile over black with lowest index first
	function automatic logic [7:0] pixel_model(input int x, input int y);
		int   t;
		int   sh;
		int   co;
		logic hit;
		t   = (y / tile_size) * tiles_per_row + x / tile_size;
		sh  = m_tsh[t];
		co  = m_tco[t];
		hit = 1'b0;
		for (int i = 0; i < num_sprites; i++) begin
			if (!hit && m_ssh[i] != 0 && x >= m_sx[i] && x < m_sx[i] + sprite_size &&
				y >= m_sy[i] && y < m_sy[i] + sprite_size) begin
				hit = 1'b1;
				sh  = m_ssh[i];
				co  = m_sco[i];
			end
		end
		if (sh == 0)
			return 8'h00;
		return {co[3:2], sh[1], co[1:0], sh[0], sh[1:0]};
	endfunction

	// Whole frame from pixel (0,0) with flags and RGB on every cycle
	task automatic check_frame(input int s);
		int         hx;
		int         vy;
		logic [3:0] exp_flags;
		logic [7:0] exp_rgb;
		for (int k = 0; k < h_total * v_total; k++) begin
			hx = k % h_total;
			vy = k / h_total;
			exp_flags = {hx >= h_active, vy >= v_active,
				!(hx >= h_sync_start && hx < h_sync_start + h_sync_len),
				!(vy >= v_sync_start && vy < v_sync_start + v_sync_len)};
			if ({h_blank, v_blank, h_sync_n, v_sync_n} !== exp_flags) begin
				timing_errs++;
				$display("mismatch at %0t: scenario %0d line %0d col %0d flags %b expected %b",
					$time, s, vy, hx, {h_blank, v_blank, h_sync_n, v_sync_n}, exp_flags);
			end
			// Blank cycles must be black
			exp_rgb = (hx < h_active && vy < v_active) ? pixel_model(hx, vy) : 8'h00;
			if ({vga_r, vga_g, vga_b} !== exp_rgb) begin
				pixel_errs++;
				$display("mismatch at %0t: scenario %0d pixel (%0d,%0d) rgb %h expected %h",
					$time, s, hx, vy, {vga_r, vga_g, vga_b}, exp_rgb);
			end
			step();
		end
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		pixel_errs  = 0;
		timing_errs = 0;
		other_errs  = 0;
		timed_out   = 1'b0;
		lfsr        = 32'he937;
		rst_n       = 1'b0;
		tile_wr     = 1'b0;
		tile_addr   = '0;
		tile_shade  = '0;
		tile_color  = '0;
		spr_wr      = 1'b0;
		spr_idx     = '0;
		spr_x       = '0;
		spr_y       = '0;
		spr_shade   = '0;
		spr_color   = '0;
		// Overlap on tile 0 plus clipping at x=28 and bottom
		tile_tab[0] = '{6'h11, 6'h00, 6'h2a, 6'h3f, 6'h00, 6'h25, 6'h17, 6'h00,
			6'h3c, 6'h09, 6'h21, 6'h32, 6'h13, 6'h00, 6'h2e, 6'h34};
		spr_tab[0]  = '{{5'd4, 5'd4, 2'd3, 4'h5}, {5'd8, 5'd6, 2'd2, 4'ha},
			{5'd28, 5'd27, 2'd1, 4'hc}, {5'd12, 5'd10, 2'd2, 4'h3}};
		// Shade-0 sprites over solid tiles
		tile_tab[1] = '{6'h36, 6'h36, 6'h36, 6'h36, 6'h36, 6'h36, 6'h36, 6'h36,
			6'h36, 6'h36, 6'h1b, 6'h36, 6'h36, 6'h36, 6'h36, 6'h36};
		spr_tab[1]  = '{{5'd12, 5'd12, 2'd0, 4'hf}, {5'd0, 5'd0, 2'd0, 4'h9},
			{5'd20, 5'd3, 2'd1, 4'h4}, {5'd2, 5'd20, 2'd0, 4'h7}};
		fill_random(2);
		fill_random(3);
		repeat (10) @(posedge clk_24576m);
		#1 rst_n = 1'b1;
		if (h_sync_n !== 1'b1 || v_sync_n !== 1'b1 || {vga_r, vga_g, vga_b} !== 8'h00) begin
			timing_errs++;
			$display("mismatch at %0t: after reset syncs %b%b rgb %h", $time, h_sync_n,
				v_sync_n, {vga_r, vga_g, vga_b});
		end
		// First frame with empty tables is black
		wait_vblank(1'b1);
		wait_vblank(1'b0);
		if (!timed_out)
			check_frame(-1);
		for (int s = 0; s < 4 && !timed_out; s++) begin
			wait_vblank(1'b0);
			wait_vblank(1'b1);
			if (!timed_out)
				apply_scenario(s);
			wait_vblank(1'b0);
			if (!timed_out)
				check_frame(s);
		end
		end_run();
	end

endmodule

//--- source/color_mix.sv
// Colour mixer
// Layer priority, 3-3-2 colour rule and timing alignment
`timescale 1ns/1ns

module color_mix (
	input  logic              clk_24576m,
	input  logic              rst_n,
	input  logic              h_blank,
	input  logic              v_blank,
	input  logic              h_sync_n,
	input  logic              v_sync_n,
	input  video_pkg::shade_t t_shade,
	input  video_pkg::color_t t_color,
	input  video_pkg::shade_t s_shade,
	input  video_pkg::color_t s_color,
	output logic [2:0]        vga_r,
	output logic [2:0]        vga_g,
	output logic [1:0]        vga_b,
	output logic              o_h_blank,
	output logic              o_v_blank,
	output logic              o_h_sync_n,
	output logic              o_v_sync_n
);
	import video_pkg::*;

	// Two-cycle delay lines to meet the layer pipelines
	logic [1:0] hb_d;
	logic [1:0] vb_d;
	logic [1:0] hs_d;
	logic [1:0] vs_d;

	shade_t     mix_shade;
	color_t     mix_color;
	logic       blank;
	logic [2:0] r_nxt;
	logic [2:0] g_nxt;
	logic [1:0] b_nxt;

	// ========================================
	// Priority and colour rule
	// ========================================
	always_comb begin
		// Sprite over tile over black
		if (s_shade != '0) begin
			mix_shade = s_shade;
			mix_color = s_color;
		end else if (t_shade != '0) begin
			mix_shade = t_shade;
			mix_color = t_color;
		end else begin
			mix_shade = '0;
			mix_color = '0;
		end
		blank = hb_d[1] | vb_d[1];
		r_nxt = blank ? '0 : {mix_color[3:2], mix_shade[1]};
		g_nxt = blank ? '0 : {mix_color[1:0], mix_shade[0]};
		b_nxt = blank ? '0 : mix_shade;
	end

	// Delay lines and output register
	always_ff @(posedge clk_24576m or negedge rst_n) begin
		if (!rst_n) begin
			hb_d       <= '0;
			vb_d       <= '0;
			hs_d       <= '1;
			vs_d       <= '1;
			vga_r      <= '0;
			vga_g      <= '0;
			vga_b      <= '0;
			o_h_blank  <= 1'b0;
			o_v_blank  <= 1'b0;
			o_h_sync_n <= 1'b1;
			o_v_sync_n <= 1'b1;
		end else begin
			hb_d       <= {hb_d[0], h_blank};
			vb_d       <= {vb_d[0], v_blank};
			hs_d       <= {hs_d[0], h_sync_n};
			vs_d       <= {vs_d[0], v_sync_n};
			vga_r      <= r_nxt;
			vga_g      <= g_nxt;
			vga_b      <= b_nxt;
			o_h_blank  <= hb_d[1];
			o_v_blank  <= vb_d[1];
			o_h_sync_n <= hs_d[1];
			o_v_sync_n <= vs_d[1];
		end
	end

endmodule

//--- source/sprite_layer.sv
// Sprite layer
// Attribute table, line buffer fill in h-blank and read-and-clear in active video
`timescale 1ns/1ns

module sprite_layer (
	input  logic                   clk_24576m,
	input  logic                   rst_n,
	input  video_pkg::hpos_t       h_cnt,
	input  video_pkg::vpos_t       v_cnt,
	input  logic                   spr_wr,
	input  video_pkg::sprite_idx_t spr_idx,
	input  video_pkg::scr_pos_t    spr_x,
	input  video_pkg::scr_pos_t    spr_y,
	input  video_pkg::shade_t      spr_shade,
	input  video_pkg::color_t      spr_color,
	output video_pkg::shade_t      s_shade,
	output video_pkg::color_t      s_color
);
	import video_pkg::*;

	// Attribute table
	scr_pos_t    tab_x     [num_sprites];
	scr_pos_t    tab_y     [num_sprites];
	shade_t      tab_shade [num_sprites];
	color_t      tab_color [num_sprites];

	// One line of sprite pixels
	shade_t      lb_shade [h_active];
	color_t      lb_color [h_active];

	spr_state_t  state;
	sprite_idx_t fill_idx;
	logic [2:0]  fill_col;
	vpos_t       next_line;
	vpos_t       dy;
	hpos_t       px;
	logic        fill_we;
	logic        rd_en;
	shade_t      rd_shade;
	color_t      rd_color;

	// ========================================
	// Fill address and coverage
	// ========================================
	always_comb begin
		// Sprite 3 first, so lower indices land on top
		fill_idx  = sprite_idx_t'(num_sprites - 1 - int'(h_cnt[4:3]));
		fill_col  = h_cnt[2:0];
		// Line after the last wraps to 0
		next_line = (v_cnt == vpos_t'(v_total - 1)) ? '0 : v_cnt + 1'b1;
		dy        = next_line - vpos_t'(tab_y[fill_idx]);
		px        = hpos_t'(tab_x[fill_idx]) + hpos_t'(fill_col);
		fill_we   = (state == SPR_FILL) &&
			(next_line >= vpos_t'(tab_y[fill_idx])) &&
			(dy < vpos_t'(sprite_size)) &&
			(next_line < vpos_t'(v_active)) &&
			(px < hpos_t'(h_active)) &&
			(tab_shade[fill_idx] != '0);
		rd_en     = (h_cnt < hpos_t'(h_active)) && (v_cnt < vpos_t'(v_active));
	end

	// Fill FSM spans h_cnt 32 to 63
	always_ff @(posedge clk_24576m or negedge rst_n) begin
		if (!rst_n) begin
			state <= SPR_IDLE;
		end else begin
			case (state)
				SPR_IDLE: if (h_cnt == hpos_t'(h_active - 1)) state <= SPR_FILL;
				SPR_FILL: if (h_cnt == hpos_t'(h_total - 1)) state <= SPR_IDLE;
				default:  state <= SPR_IDLE;
			endcase
		end
	end

	// Table write port
	always_ff @(posedge clk_24576m or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < num_sprites; i++) begin
				tab_x[i]     <= '0;
				tab_y[i]     <= '0;
				tab_shade[i] <= '0;
				tab_color[i] <= '0;
			end
		end else if (spr_wr) begin
			tab_x[spr_idx]     <= spr_x;
			tab_y[spr_idx]     <= spr_y;
			tab_shade[spr_idx] <= spr_shade;
			tab_color[spr_idx] <= spr_color;
		end
	end

	// ========================================
	// Line buffer
	// ========================================
	// Fill and clear never share a cycle
	always_ff @(posedge clk_24576m or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < h_active; i++) begin
				lb_shade[i] <= '0;
				lb_color[i] <= '0;
			end
		end else if (fill_we) begin
			lb_shade[px[4:0]] <= tab_shade[fill_idx];
			lb_color[px[4:0]] <= tab_color[fill_idx];
		end else if (rd_en) begin
			// Clear behind the read, ready for next fill
			lb_shade[h_cnt[4:0]] <= '0;
			lb_color[h_cnt[4:0]] <= '0;
		end
	end

	// Read stage then output stage
	always_ff @(posedge clk_24576m or negedge rst_n) begin
		if (!rst_n) begin
			rd_shade <= '0;
			rd_color <= '0;
			s_shade  <= '0;
			s_color  <= '0;
		end else begin
			rd_shade <= rd_en ? lb_shade[h_cnt[4:0]] : '0;
			rd_color <= rd_en ? lb_color[h_cnt[4:0]] : '0;
			s_shade  <= rd_shade;
			s_color  <= rd_color;
		end
	end

endmodule

//--- source/tile_layer.sv
// Tile layer
// Character map with write port and two-stage pixel lookup
`timescale 1ns/1ns

module tile_layer (
	input  logic                  clk_24576m,
	input  logic                  rst_n,
	input  video_pkg::hpos_t      h_cnt,
	input  video_pkg::vpos_t      v_cnt,
	input  logic                  tile_wr,
	input  video_pkg::tile_addr_t tile_addr,
	input  video_pkg::shade_t     tile_shade,
	input  video_pkg::color_t     tile_color,
	output video_pkg::shade_t     t_shade,
	output video_pkg::color_t     t_color
);
	import video_pkg::*;

	// Map storage, one entry per 8x8 tile
	shade_t     map_shade [tiles_per_row * (v_active / tile_size)];
	color_t     map_color [tiles_per_row * (v_active / tile_size)];

	tile_addr_t rd_addr;
	logic       vis;

	// Stage 1 holds the entry for the current count
	shade_t     st1_shade;
	color_t     st1_color;
	logic       st1_vis;

	// Row times four plus column
	assign rd_addr = tile_addr_t'((v_cnt / tile_size) * tiles_per_row + h_cnt / tile_size);
	assign vis     = (h_cnt < hpos_t'(h_active)) && (v_cnt < vpos_t'(v_active));

	// ========================================
	// Map write port
	// ========================================
	always_ff @(posedge clk_24576m or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < tiles_per_row * (v_active / tile_size); i++) begin
				map_shade[i] <= '0;
				map_color[i] <= '0;
			end
		end else if (tile_wr) begin
			map_shade[tile_addr] <= tile_shade;
			map_color[tile_addr] <= tile_color;
		end
	end

	// ========================================
	// Pixel pipeline
	// ========================================
	// Stage 1 reads the map entry
	always_ff @(posedge clk_24576m or negedge rst_n) begin
		if (!rst_n) begin
			st1_shade <= '0;
			st1_color <= '0;
			st1_vis   <= 1'b0;
		end else begin
			st1_shade <= map_shade[rd_addr];
			st1_color <= map_color[rd_addr];
			st1_vis   <= vis;
		end
	end

	// Stage 2 output, transparent outside visible area
	always_ff @(posedge clk_24576m or negedge rst_n) begin
		if (!rst_n) begin
			t_shade <= '0;
			t_color <= '0;
		end else begin
			t_shade <= st1_vis ? st1_shade : '0;
			t_color <= st1_vis ? st1_color : '0;
		end
	end

endmodule

//--- source/video_pkg.sv
// Video package
// Raster constants, field widths and sprite FSM states
package video_pkg;

	// ========================================
	// Raster geometry
	// ========================================
	localparam int h_total       = 64;
	localparam int h_active      = 32;
	localparam int h_sync_start  = 40;
	localparam int h_sync_len    = 8;
	localparam int v_total       = 40;
	localparam int v_active      = 32;
	localparam int v_sync_start  = 34;
	localparam int v_sync_len    = 2;

	// Layer geometry
	localparam int tile_size     = 8;
	localparam int tiles_per_row = 4;
	localparam int num_sprites   = 4;
	localparam int sprite_size   = 8;

	// ========================================
	// Field types
	// ========================================
	typedef logic [5:0] hpos_t;
	typedef logic [5:0] vpos_t;
	typedef logic [4:0] scr_pos_t;
	typedef logic [3:0] color_t;
	typedef logic [1:0] shade_t;
	typedef logic [3:0] tile_addr_t;
	typedef logic [1:0] sprite_idx_t;

	typedef enum logic {SPR_IDLE, SPR_FILL} spr_state_t;

endpackage

//--- source/video_timing.sv
// Raster timing generator
// Pixel and line counters with registered blank and active-low sync
`timescale 1ns/1ns

module video_timing (
	input  logic             clk_24576m,
	input  logic             rst_n,
	output video_pkg::hpos_t h_cnt,
	output video_pkg::vpos_t v_cnt,
	output logic             h_blank,
	output logic             v_blank,
	output logic             h_sync_n,
	output logic             v_sync_n
);
	import video_pkg::*;

	hpos_t h_nxt;
	vpos_t v_nxt;
	logic  h_wrap;
	logic  h_sync_on;
	logic  v_sync_on;

	// Next counter state
	always_comb begin
		h_wrap = (h_cnt == hpos_t'(h_total - 1));
		h_nxt  = h_wrap ? '0 : h_cnt + 1'b1;
		// Line count steps only at end of line
		if (h_wrap) begin
			v_nxt = (v_cnt == vpos_t'(v_total - 1)) ? '0 : v_cnt + 1'b1;
		end else begin
			v_nxt = v_cnt;
		end
		// Sync windows on the next count
		h_sync_on = (h_nxt >= hpos_t'(h_sync_start)) &&
			(h_nxt < hpos_t'(h_sync_start + h_sync_len));
		v_sync_on = (v_nxt >= vpos_t'(v_sync_start)) &&
			(v_nxt < vpos_t'(v_sync_start + v_sync_len));
	end

	// ========================================
	// Counters and decodes
	// ========================================
	// Decode from next count so flags move with counters
	always_ff @(posedge clk_24576m or negedge rst_n) begin
		if (!rst_n) begin
			h_cnt    <= '0;
			v_cnt    <= '0;
			h_blank  <= 1'b0;
			v_blank  <= 1'b0;
			h_sync_n <= 1'b1;
			v_sync_n <= 1'b1;
		end else begin
			h_cnt    <= h_nxt;
			v_cnt    <= v_nxt;
			h_blank  <= (h_nxt >= hpos_t'(h_active));
			v_blank  <= (v_nxt >= vpos_t'(v_active));
			h_sync_n <= !h_sync_on;
			v_sync_n <= !v_sync_on;
		end
	end

endmodule

//--- source/video_top.sv
// Video top level
// Raster timing, tile and sprite layers and colour mixer
`timescale 1ns/1ns

module video_top (
	input  logic                   clk_24576m,
	input  logic                   rst_n,
	input  logic                   tile_wr,
	input  video_pkg::tile_addr_t  tile_addr,
	input  video_pkg::shade_t      tile_shade,
	input  video_pkg::color_t      tile_color,
	input  logic                   spr_wr,
	input  video_pkg::sprite_idx_t spr_idx,
	input  video_pkg::scr_pos_t    spr_x,
	input  video_pkg::scr_pos_t    spr_y,
	input  video_pkg::shade_t      spr_shade,
	input  video_pkg::color_t      spr_color,
	output logic [2:0]             vga_r,
	output logic [2:0]             vga_g,
	output logic [1:0]             vga_b,
	output logic                   h_blank,
	output logic                   v_blank,
	output logic                   h_sync_n,
	output logic                   v_sync_n
);
	import video_pkg::*;

	// ========================================
	// Raster counters and flags
	// ========================================
	hpos_t  h_cnt;
	vpos_t  v_cnt;
	logic   tm_h_blank;
	logic   tm_v_blank;
	logic   tm_h_sync_n;
	logic   tm_v_sync_n;

	// Layer pixels, two cycles behind the counters
	shade_t t_shade;
	color_t t_color;
	shade_t s_shade;
	color_t s_color;

	video_timing video_timing_inst (
		.clk_24576m(clk_24576m), .rst_n(rst_n),
		.h_cnt(h_cnt), .v_cnt(v_cnt),
		.h_blank(tm_h_blank), .v_blank(tm_v_blank),
		.h_sync_n(tm_h_sync_n), .v_sync_n(tm_v_sync_n)
	);

	tile_layer tile_layer_inst (
		.clk_24576m(clk_24576m), .rst_n(rst_n),
		.h_cnt(h_cnt), .v_cnt(v_cnt),
		.tile_wr(tile_wr), .tile_addr(tile_addr),
		.tile_shade(tile_shade), .tile_color(tile_color),
		.t_shade(t_shade), .t_color(t_color)
	);

	sprite_layer sprite_layer_inst (
		.clk_24576m(clk_24576m), .rst_n(rst_n),
		.h_cnt(h_cnt), .v_cnt(v_cnt),
		.spr_wr(spr_wr), .spr_idx(spr_idx), .spr_x(spr_x), .spr_y(spr_y),
		.spr_shade(spr_shade), .spr_color(spr_color),
		.s_shade(s_shade), .s_color(s_color)
	);

	// Final stage drives every top-level output
	color_mix color_mix_inst (
		.clk_24576m(clk_24576m), .rst_n(rst_n),
		.h_blank(tm_h_blank), .v_blank(tm_v_blank),
		.h_sync_n(tm_h_sync_n), .v_sync_n(tm_v_sync_n),
		.t_shade(t_shade), .t_color(t_color),
		.s_shade(s_shade), .s_color(s_color),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
		.o_h_blank(h_blank), .o_v_blank(v_blank),
		.o_h_sync_n(h_sync_n), .o_v_sync_n(v_sync_n)
	);

endmodule
